//--- rtl/osd_pkg.sv
// osd package: widths, types, command codes, window geometry and version bytes
`default_nettype none

package osd_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int SPI_BYTE_W    = 8;
  localparam int OSD_ADDR_W    = 11;
  localparam int HPOS_W        = 11;
  localparam int VPOS_W        = 9;
  localparam int OSD_BUF_DEPTH = 1 << OSD_ADDR_W;

  // flops on sck/sdi/cs_n before use
  localparam int SCK_SYNC_STAGES = 2;

  // data byte counter stops here
  localparam logic [2:0] DAT_CNT_MAX = 3'd4;

  // ------------------------------
  // types
  // ------------------------------
  typedef logic [SPI_BYTE_W-1:0] spi_byte_t;
  // row in [10:8], column in [7:0]
  typedef logic [OSD_ADDR_W-1:0] osd_addr_t;
  typedef logic [HPOS_W-1:0]     hpos_t;
  typedef logic [VPOS_W-1:0]     vpos_t;
  typedef logic [4:0]            chipset_cfg_t;
  // dither, hires filter, lores filter, scanline (2 bits each, msb first)
  typedef logic [7:0]            video_cfg_t;
  typedef logic [3:0]            floppy_cfg_t;

  // decoded command of the current frame
  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_RESET_CTRL,
    SEL_OSD_CTRL,
    SEL_CHIP_CFG,
    SEL_VIDEO_CFG,
    SEL_FLOPPY_CFG,
    SEL_OSD_BUFFER,
    SEL_VERSION
  } cmd_sel_e;

  // ------------------------------
  // command bytes
  // ------------------------------
  localparam spi_byte_t CMD_RESET_CTRL = 8'h08;
  localparam spi_byte_t CMD_OSD_CTRL   = 8'h28;
  localparam spi_byte_t CMD_CHIP_CFG   = 8'h04;
  localparam spi_byte_t CMD_VIDEO_CFG  = 8'h34;
  localparam spi_byte_t CMD_FLOPPY_CFG = 8'h44;
  localparam spi_byte_t CMD_OSD_BUFFER = 8'h0C;
  localparam spi_byte_t CMD_VERSION    = 8'h88;

  // window geometry in beam counts
  localparam hpos_t OSD_H_START = 11'd64;
  localparam hpos_t OSD_WIDTH   = 11'd256;
  localparam vpos_t OSD_V_START = 9'd16;
  localparam vpos_t OSD_HEIGHT  = 9'd64;

  // version string returned on read
  localparam spi_byte_t VERSION_BETA  = 8'h42;
  localparam spi_byte_t VERSION_MAJOR = 8'h01;
  localparam spi_byte_t VERSION_MINOR = 8'h03;
  localparam spi_byte_t VERSION_SEP   = 8'h2E;

endpackage

`default_nettype wire

//--- rtl/osd_spi_slave.sv
// spi mode-0 slave: pin sync, sck edge detect, byte framing, command flag, sdo shifter
`timescale 1ns/1ps
`default_nettype none

module osd_spi_slave import osd_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      spi_cs_n,
  input  logic      spi_sck,
  input  logic      spi_sdi,
  input  spi_byte_t tx_data,
  output logic      spi_sdo,
  output logic      rx_valid,
  output logic      rx_is_cmd,
  output logic      frame_active,
  output spi_byte_t rx_data
);

  logic [SCK_SYNC_STAGES-1:0] sck_sync;
  logic [SCK_SYNC_STAGES-1:0] sdi_sync;
  logic [SCK_SYNC_STAGES-1:0] cs_sync;
  logic                       sck_q;
  logic                       sck_s;
  logic                       sdi_s;
  logic                       cs_active;
  logic                       sck_rise;
  logic                       sck_fall;
  logic                       frame_start;
  logic [2:0]                 bit_cnt;
  logic                       first_byte;
  spi_byte_t                  rx_shift;
  spi_byte_t                  tx_shift;

  // ------------------------------
  // pin synchronizers
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      sck_sync <= '0;
      cs_sync  <= '1;
      sck_q    <= 1'b0;
    end else begin
      sck_sync <= {sck_sync[SCK_SYNC_STAGES-2:0], spi_sck};
      cs_sync  <= {cs_sync[SCK_SYNC_STAGES-2:0], spi_cs_n};
      sck_q    <= sck_s;
    end
  end

  // sdi delayed the same as sck
  always_ff @(posedge clk) begin
    sdi_sync <= {sdi_sync[SCK_SYNC_STAGES-2:0], spi_sdi};
  end

  assign sck_s       = sck_sync[SCK_SYNC_STAGES-1];
  assign sdi_s       = sdi_sync[SCK_SYNC_STAGES-1];
  assign cs_active   = ~cs_sync[SCK_SYNC_STAGES-1];
  assign sck_rise    = sck_s & ~sck_q;
  assign sck_fall    = ~sck_s & sck_q;
  // cs seen low, frame flag not yet set
  assign frame_start = cs_active & ~frame_active;

  // ------------------------------
  // bit counter and byte strobe
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      frame_active <= 1'b0;
      bit_cnt      <= 3'd0;
      first_byte   <= 1'b1;
      rx_valid     <= 1'b0;
      rx_is_cmd    <= 1'b0;
    end else begin
      frame_active <= cs_active;
      rx_valid     <= 1'b0;
      if (!cs_active) begin
        // frame over, next byte is a command again
        bit_cnt    <= 3'd0;
        first_byte <= 1'b1;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          rx_valid   <= 1'b1;
          rx_is_cmd  <= first_byte;
          first_byte <= 1'b0;
        end
      end
    end
  end

  // receive shifter, msb first
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[6:0], sdi_s};
      if (bit_cnt == 3'd7) begin
        rx_data <= {rx_shift[6:0], sdi_s};
      end
    end
  end

  // ------------------------------
  // transmit shifter
  // ------------------------------
  // load at frame start and with every received byte
  // the fall right after bit 8 keeps the fresh msb on sdo
  always_ff @(posedge clk) begin
    if (frame_start || rx_valid) begin
      tx_shift <= tx_data;
    end else if (sck_fall && bit_cnt != 3'd0) begin
      tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  assign spi_sdo = tx_shift[7];

  // byte strobes only inside a frame
  assert property (@(posedge clk) disable iff (reset) rx_valid |-> frame_active);

endmodule

`default_nettype wire

//--- rtl/osd_cmd_regs.sv
// command decoder: byte counter, config and reset registers, buffer write port, read data
`timescale 1ns/1ps
`default_nettype none

module osd_cmd_regs import osd_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         rx_valid,
  input  logic         rx_is_cmd,
  input  logic         frame_active,
  input  spi_byte_t    rx_data,
  input  spi_byte_t    osd_ctrl,
  output spi_byte_t    tx_data,
  output logic         buf_we,
  output osd_addr_t    buf_addr,
  output spi_byte_t    buf_data,
  output logic         osd_enable,
  output logic         key_disable,
  output logic         usrrst,
  output logic         cpurst,
  output logic         cpuhlt,
  output chipset_cfg_t chipset_config,
  output video_cfg_t   video_cfg,
  output floppy_cfg_t  floppy_config
);

  cmd_sel_e     cmd_sel;
  cmd_sel_e     sel_nxt;
  logic [2:0]   dat_cnt;
  logic [2:0]   cnt_nxt;
  logic         data_rx;
  logic         first_data;
  logic         buf_sel;
  chipset_cfg_t chipset_stage;
  spi_byte_t    version_byte;

  // command byte to select
  function automatic cmd_sel_e decode_cmd(input spi_byte_t cmd);
    case (cmd)
      CMD_RESET_CTRL: return SEL_RESET_CTRL;
      CMD_OSD_CTRL:   return SEL_OSD_CTRL;
      CMD_CHIP_CFG:   return SEL_CHIP_CFG;
      CMD_VIDEO_CFG:  return SEL_VIDEO_CFG;
      CMD_FLOPPY_CFG: return SEL_FLOPPY_CFG;
      CMD_OSD_BUFFER: return SEL_OSD_BUFFER;
      CMD_VERSION:    return SEL_VERSION;
      default:        return SEL_NONE;
    endcase
  endfunction

  // ------------------------------
  // command latch and byte counter
  // ------------------------------
  always_comb begin
    sel_nxt = cmd_sel;
    cnt_nxt = dat_cnt;
    // end of frame drops the command
    if (!frame_active) begin
      sel_nxt = SEL_NONE;
    end
    if (rx_valid) begin
      if (rx_is_cmd) begin
        sel_nxt = decode_cmd(rx_data);
        cnt_nxt = 3'd0;
      end else if (dat_cnt != DAT_CNT_MAX) begin
        cnt_nxt = dat_cnt + 3'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_sel <= SEL_NONE;
      dat_cnt <= 3'd0;
    end else begin
      cmd_sel <= sel_nxt;
      dat_cnt <= cnt_nxt;
    end
  end

  assign data_rx    = rx_valid & ~rx_is_cmd;
  assign first_data = data_rx && (dat_cnt == 3'd0);
  assign buf_sel    = (cmd_sel == SEL_OSD_BUFFER);

  // ------------------------------
  // registers, written by data byte 0
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      cpuhlt         <= 1'b1;
      cpurst         <= 1'b1;
      usrrst         <= 1'b0;
      key_disable    <= 1'b0;
      osd_enable     <= 1'b0;
      chipset_stage  <= '0;
      chipset_config <= '0;
      video_cfg      <= '0;
      floppy_config  <= '0;
    end else begin
      if (first_data) begin
        case (cmd_sel)
          SEL_RESET_CTRL: {cpuhlt, cpurst, usrrst} <= rx_data[2:0];
          SEL_OSD_CTRL:   {key_disable, osd_enable} <= rx_data[1:0];
          SEL_CHIP_CFG:   chipset_stage <= rx_data[4:0];
          SEL_VIDEO_CFG:  video_cfg <= rx_data;
          SEL_FLOPPY_CFG: floppy_config <= rx_data[3:0];
          default: ;
        endcase
      end
      // chipset only follows the staged value while the cpu is held
      if (cpurst) begin
        chipset_config <= chipset_stage;
      end
    end
  end

  // ------------------------------
  // display buffer write port
  // ------------------------------
  // bytes 0 and 1 carry the address, data from byte 2 on
  always_ff @(posedge clk) begin
    if (reset) begin
      buf_we <= 1'b0;
    end else begin
      buf_we <= data_rx && buf_sel && (dat_cnt >= 3'd2);
    end
  end

  always_ff @(posedge clk) begin
    if (data_rx) begin
      buf_data <= rx_data;
    end
  end

  always_ff @(posedge clk) begin
    if (first_data && buf_sel) begin
      buf_addr[10:8] <= rx_data[2:0];
    end else if (data_rx && buf_sel && dat_cnt == 3'd1) begin
      buf_addr[7:0] <= rx_data;
    end else if (buf_we) begin
      // next column after each write
      buf_addr <= buf_addr + 11'd1;
    end
  end

  // ------------------------------
  // read data
  // ------------------------------
  // slave loads tx_data with rx_valid, so look at the state after this byte
  always_comb begin
    case (cnt_nxt)
      3'd0:    version_byte = VERSION_BETA;
      3'd1:    version_byte = VERSION_MAJOR;
      3'd2:    version_byte = VERSION_MINOR;
      default: version_byte = VERSION_SEP;
    endcase
  end

  assign tx_data = (sel_nxt == SEL_VERSION) ? version_byte : osd_ctrl;

  // buffer writes belong to a buffer frame
  assert property (@(posedge clk) disable iff (reset) buf_we |-> cmd_sel == SEL_OSD_BUFFER);

endmodule

`default_nettype wire

//--- rtl/osd_video.sv
// osd video: beam counters, window decode, display buffer and blank/pixel outputs
`timescale 1ns/1ps
`default_nettype none

module osd_video import osd_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      sol,
  input  logic      sof,
  input  logic      osd_enable,
  input  logic      buf_we,
  input  osd_addr_t buf_addr,
  input  spi_byte_t buf_data,
  output logic      osd_blank,
  output logic      osd_pixel
);

  hpos_t     hcnt;
  vpos_t     vcnt;
  hpos_t     hrel;
  vpos_t     vrel;
  logic      osd_on;
  logic      h_in;
  logic      v_in;
  osd_addr_t rd_addr;
  spi_byte_t rd_data;
  logic      win_q;
  logic [2:0] bit_q;

  // 2k x 8 display buffer
  spi_byte_t osd_buf [OSD_BUF_DEPTH];

  // ------------------------------
  // beam counters
  // ------------------------------
  // horizontal, 0 in the cycle after sol
  always_ff @(posedge clk) begin
    if (reset) begin
      hcnt <= '0;
    end else if (sol) begin
      hcnt <= '0;
    end else begin
      hcnt <= hcnt + 11'd1;
    end
  end

  // vertical, lines since sof
  always_ff @(posedge clk) begin
    if (reset) begin
      vcnt <= '0;
    end else if (sof) begin
      vcnt <= '0;
    end else if (sol) begin
      vcnt <= vcnt + 9'd1;
    end
  end

  // enable only changes at frame start
  always_ff @(posedge clk) begin
    if (reset) begin
      osd_on <= 1'b0;
    end else if (sof) begin
      osd_on <= osd_enable;
    end
  end

  // ------------------------------
  // window decode
  // ------------------------------
  assign h_in = (hcnt >= OSD_H_START) && (hcnt < OSD_H_START + OSD_WIDTH);
  assign v_in = (vcnt >= OSD_V_START) && (vcnt < OSD_V_START + OSD_HEIGHT);

  // position inside the window
  assign hrel = hcnt - OSD_H_START;
  assign vrel = vcnt - OSD_V_START;

  // text row from line / 8, column from h
  assign rd_addr = {vrel[5:3], hrel[7:0]};

  // ------------------------------
  // display buffer
  // ------------------------------
  always_ff @(posedge clk) begin
    if (buf_we) begin
      osd_buf[buf_addr] <= buf_data;
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= osd_buf[rd_addr];
    // bit within the byte is the line inside the text row
    bit_q   <= vrel[2:0];
  end

  // window flag delayed along with the read
  always_ff @(posedge clk) begin
    if (reset) begin
      win_q <= 1'b0;
    end else begin
      win_q <= h_in & v_in & osd_on;
    end
  end

  // ------------------------------
  // output register
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      osd_blank <= 1'b0;
      osd_pixel <= 1'b0;
    end else begin
      osd_blank <= win_q;
      osd_pixel <= win_q & rd_data[bit_q];
    end
  end

  // pixels only drawn inside the blanked window
  assert property (@(posedge clk) disable iff (reset) osd_pixel |-> osd_blank);

endmodule

`default_nettype wire

//--- rtl/osd_top.sv
// osd top: spi slave, command decoder and video generator
`timescale 1ns/1ps
`default_nettype none

module osd_top import osd_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         spi_cs_n,
  input  logic         spi_sck,
  input  logic         spi_sdi,
  input  logic         sol,
  input  logic         sof,
  input  spi_byte_t    osd_ctrl,
  output logic         spi_sdo,
  output logic         osd_blank,
  output logic         osd_pixel,
  output logic         osd_enable,
  output logic         key_disable,
  output logic         usrrst,
  output logic         cpurst,
  output logic         cpuhlt,
  output chipset_cfg_t chipset_config,
  output video_cfg_t   video_cfg,
  output floppy_cfg_t  floppy_config
);

  // byte stream between slave and decoder
  spi_byte_t tx_data;
  spi_byte_t rx_data;
  logic      rx_valid;
  logic      rx_is_cmd;
  logic      frame_active;

  // display buffer write port
  logic      buf_we;
  osd_addr_t buf_addr;
  spi_byte_t buf_data;

  osd_spi_slave spi_i (
    .clk          (clk),
    .reset        (reset),
    .spi_cs_n     (spi_cs_n),
    .spi_sck      (spi_sck),
    .spi_sdi      (spi_sdi),
    .tx_data      (tx_data),
    .spi_sdo      (spi_sdo),
    .rx_valid     (rx_valid),
    .rx_is_cmd    (rx_is_cmd),
    .frame_active (frame_active),
    .rx_data      (rx_data)
  );

  osd_cmd_regs regs_i (
    .clk            (clk),
    .reset          (reset),
    .rx_valid       (rx_valid),
    .rx_is_cmd      (rx_is_cmd),
    .frame_active   (frame_active),
    .rx_data        (rx_data),
    .osd_ctrl       (osd_ctrl),
    .tx_data        (tx_data),
    .buf_we         (buf_we),
    .buf_addr       (buf_addr),
    .buf_data       (buf_data),
    .osd_enable     (osd_enable),
    .key_disable    (key_disable),
    .usrrst         (usrrst),
    .cpurst         (cpurst),
    .cpuhlt         (cpuhlt),
    .chipset_config (chipset_config),
    .video_cfg      (video_cfg),
    .floppy_config  (floppy_config)
  );

  osd_video video_i (
    .clk        (clk),
    .reset      (reset),
    .sol        (sol),
    .sof        (sof),
    .osd_enable (osd_enable),
    .buf_we     (buf_we),
    .buf_addr   (buf_addr),
    .buf_data   (buf_data),
    .osd_blank  (osd_blank),
    .osd_pixel  (osd_pixel)
  );

endmodule

`default_nettype wire

//--- include/osd_tb_tasks.svh
// testbench helpers: error stop, clock step, compare tasks, video line capture and check
`ifndef OSD_TB_TASKS_SVH
`define OSD_TB_TASKS_SVH

  // print the reason, then end the run
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  // inputs change shortly after the rising edge
  task automatic tick();
    @(posedge clk);
    #5;
  endtask

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_byte(input string name, input spi_byte_t got, input spi_byte_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_chipset(input string name, input chipset_cfg_t got,
                               input chipset_cfg_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_video(input string name, input video_cfg_t got, input video_cfg_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_floppy(input string name, input floppy_cfg_t got,
                              input floppy_cfg_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // ------------------------------
  // video capture
  // ------------------------------
  // one line of LINE_LEN clk, sol in the first, sof too on line 0
  task automatic drive_line(input bit first);
    for (int t = 0; t < LINE_LEN; t++) begin
      tick();
      line_blank[t] = osd_blank;
      line_pixel[t] = osd_pixel;
      sol = (t == 0);
      sof = (t == 0) && first;
    end
  endtask

  // blank run position is free, only its length and contents count
  task automatic check_line(input int v, input bit enabled);
    int first_idx;
    int run_len;
    int vrel;
    bit in_rows;
    first_idx = -1;
    run_len   = 0;
    vrel      = v - int'(OSD_V_START);
    in_rows   = enabled && (vrel >= 0) && (vrel < int'(OSD_HEIGHT));
    for (int t = 0; t < LINE_LEN; t++) begin
      if (line_blank[t] === 1'b1) begin
        if (first_idx < 0) begin
          first_idx = t;
        end
        run_len++;
      end else if (line_pixel[t] !== 1'b0) begin
        stop_on_error($sformatf("pixel set outside the window in line %0d", v));
      end
    end
    if (!in_rows) begin
      if (run_len != 0) begin
        stop_on_error($sformatf("blank seen outside the window rows in line %0d", v));
      end
    end else begin
      if (run_len != int'(OSD_WIDTH)) begin
        stop_on_error($sformatf("blank run of %0d cycles in line %0d", run_len, v));
      end
      for (int c = 0; c < int'(OSD_WIDTH); c++) begin
        if (line_blank[first_idx + c] !== 1'b1) begin
          stop_on_error($sformatf("blank run split in line %0d", v));
        end
        // only the written row holds known data
        if (vrel / 8 == PAT_ROW) begin
          check_bit($sformatf("osd_pixel line %0d col %0d", v, c),
                    line_pixel[first_idx + c], row_pat[c][vrel % 8]);
        end
      end
    end
  endtask

  task automatic run_frame(input bit enabled);
    for (int v = 0; v < N_LINES; v++) begin
      drive_line(v == 0);
      check_line(v, enabled);
    end
  endtask

`endif

//--- verif/osd_tb.sv
// osd testbench: clock, reset, watchdog, dut, spi driver and directed tests
`timescale 1ns/1ps
`default_nettype none

module osd_tb import osd_pkg::*; ();

  // ------------------------------
  // timing of the bench
  // ------------------------------
  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 8;
  localparam int SCK_HALF     = 8;
  localparam int LINE_LEN     = 400;
  // a few spare lines below the window
  localparam int N_LINES      = int'(OSD_V_START) + int'(OSD_HEIGHT) + 8;
  // text row filled by the buffer test
  localparam int PAT_ROW      = 1;

  // nominal length of the tests in clk
  localparam int SPI_BYTE_CYCLES = 2 * SCK_HALF * 8;
  localparam int SPI_GAP_CYCLES  = 2 * SCK_HALF;
  localparam int FRAME_CYCLES    = LINE_LEN * N_LINES;
  localparam int SPI_BYTES       = 9 + 6 + 9 + 3 + int'(OSD_WIDTH) + 2;
  localparam int SPI_FRAMES      = 3 + 3 + 2 + 2;
  localparam int NOMINAL_CYCLES  = RESET_CYCLES + 2 * FRAME_CYCLES
                                 + SPI_BYTES * SPI_BYTE_CYCLES + SPI_FRAMES * SPI_GAP_CYCLES;

  logic         clk;
  logic         reset;
  logic         spi_cs_n;
  logic         spi_sck;
  logic         spi_sdi;
  logic         sol;
  logic         sof;
  spi_byte_t    osd_ctrl;
  logic         spi_sdo;
  logic         osd_blank;
  logic         osd_pixel;
  logic         osd_enable;
  logic         key_disable;
  logic         usrrst;
  logic         cpurst;
  logic         cpuhlt;
  chipset_cfg_t chipset_config;
  video_cfg_t   video_cfg;
  floppy_cfg_t  floppy_config;

  integer       seed;
  // bytes sent on sdi and bytes seen on sdo
  spi_byte_t    mosi_q[$];
  spi_byte_t    miso_q[$];
  // one captured video line
  logic         line_blank [LINE_LEN];
  logic         line_pixel [LINE_LEN];
  // pattern written to the display buffer
  spi_byte_t    row_pat [OSD_WIDTH];

  osd_top dut_i (
    .clk            (clk),
    .reset          (reset),
    .spi_cs_n       (spi_cs_n),
    .spi_sck        (spi_sck),
    .spi_sdi        (spi_sdi),
    .sol            (sol),
    .sof            (sof),
    .osd_ctrl       (osd_ctrl),
    .spi_sdo        (spi_sdo),
    .osd_blank      (osd_blank),
    .osd_pixel      (osd_pixel),
    .osd_enable     (osd_enable),
    .key_disable    (key_disable),
    .usrrst         (usrrst),
    .cpurst         (cpurst),
    .cpuhlt         (cpuhlt),
    .chipset_config (chipset_config),
    .video_cfg      (video_cfg),
    .floppy_config  (floppy_config)
  );

  `include "osd_tb_tasks.svh"

  initial begin
    clk = 1'b0;
  end

  always #(CLK_PERIOD / 2) clk = ~clk;

  // twice the nominal run
  initial begin
    #(2 * NOMINAL_CYCLES * CLK_PERIOD);
    stop_on_error("timeout, the tests did not finish in time");
  end

  // ------------------------------
  // spi driver
  // ------------------------------
  // mode 0, msb first, sdo taken at each sck rise
  task automatic spi_transfer();
    spi_byte_t rx;
    miso_q.delete();
    spi_cs_n = 1'b0;
    foreach (mosi_q[i]) begin
      for (int b = 7; b >= 0; b--) begin
        spi_sdi = mosi_q[i][b];
        repeat (SCK_HALF) tick();
        spi_sck = 1'b1;
        rx[b] = spi_sdo;
        repeat (SCK_HALF) tick();
        spi_sck = 1'b0;
      end
      miso_q.push_back(rx);
    end
    repeat (SCK_HALF) tick();
    spi_cs_n = 1'b1;
    // let the frame end reach the decoder
    repeat (SCK_HALF) tick();
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic test_reset_values();
    check_bit("cpurst", cpurst, 1'b1);
    check_bit("cpuhlt", cpuhlt, 1'b1);
    check_bit("usrrst", usrrst, 1'b0);
    check_bit("osd_enable", osd_enable, 1'b0);
    check_bit("key_disable", key_disable, 1'b0);
    check_video("video_cfg", video_cfg, '0);
    check_floppy("floppy_config", floppy_config, '0);
    check_chipset("chipset_config", chipset_config, '0);
    // osd off, so no blank anywhere in the frame
    run_frame(1'b0);
  endtask

  task automatic test_direct_regs();
    spi_byte_t vid_d;
    spi_byte_t flp_d;
    spi_byte_t ctl_d;
    vid_d = spi_byte_t'($random(seed));
    flp_d = spi_byte_t'($random(seed));
    ctl_d = spi_byte_t'($random(seed));
    // trailing bytes must be ignored
    mosi_q = '{CMD_VIDEO_CFG, vid_d, ~vid_d};
    spi_transfer();
    check_video("video_cfg", video_cfg, vid_d);
    mosi_q = '{CMD_FLOPPY_CFG, flp_d, ~flp_d};
    spi_transfer();
    check_floppy("floppy_config", floppy_config, flp_d[3:0]);
    mosi_q = '{CMD_OSD_CTRL, ctl_d, ~ctl_d};
    spi_transfer();
    check_bit("osd_enable", osd_enable, ctl_d[0]);
    check_bit("key_disable", key_disable, ctl_d[1]);
  endtask

  task automatic test_chipset_staging();
    chipset_cfg_t stage;
    // nonzero so the copy is visible
    stage = chipset_cfg_t'($random(seed)) | 5'h01;
    mosi_q = '{CMD_RESET_CTRL, 8'h00};
    spi_transfer();
    check_bit("cpurst", cpurst, 1'b0);
    check_bit("cpuhlt", cpuhlt, 1'b0);
    check_bit("usrrst", usrrst, 1'b0);
    mosi_q = '{CMD_CHIP_CFG, {3'b000, stage}};
    spi_transfer();
    // nothing staged earlier, so still the reset value
    check_chipset("chipset_config", chipset_config, '0);
    // cpu back into reset, staged value goes through
    mosi_q = '{CMD_RESET_CTRL, 8'h02};
    spi_transfer();
    check_bit("cpurst", cpurst, 1'b1);
    check_chipset("chipset_config", chipset_config, stage);
  endtask

  task automatic test_read_back();
    spi_byte_t exp_q[$];
    osd_ctrl = spi_byte_t'($random(seed));
    mosi_q = '{CMD_VERSION, 8'h11, 8'h22, 8'h33, 8'h44, 8'h55};
    spi_transfer();
    // command byte goes out before the command is decoded
    exp_q = '{osd_ctrl, VERSION_BETA, VERSION_MAJOR, VERSION_MINOR, VERSION_SEP, VERSION_SEP};
    foreach (exp_q[i]) begin
      check_byte($sformatf("spi_sdo version byte %0d", i), miso_q[i], exp_q[i]);
    end
    // unknown command reads osd_ctrl throughout
    mosi_q = '{8'h55, 8'hA0, 8'h0F};
    spi_transfer();
    foreach (miso_q[i]) begin
      check_byte($sformatf("spi_sdo other byte %0d", i), miso_q[i], osd_ctrl);
    end
  endtask

  task automatic test_buffer_pixels();
    mosi_q = '{CMD_OSD_BUFFER, spi_byte_t'(PAT_ROW), 8'h00};
    for (int c = 0; c < int'(OSD_WIDTH); c++) begin
      row_pat[c] = spi_byte_t'($random(seed));
      mosi_q.push_back(row_pat[c]);
    end
    spi_transfer();
    mosi_q = '{CMD_OSD_CTRL, 8'h01};
    spi_transfer();
    check_bit("osd_enable", osd_enable, 1'b1);
    run_frame(1'b1);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    seed     = 5;
    reset    = 1'b1;
    spi_cs_n = 1'b1;
    spi_sck  = 1'b0;
    spi_sdi  = 1'b0;
    sol      = 1'b0;
    sof      = 1'b0;
    osd_ctrl = '0;
    repeat (RESET_CYCLES) tick();
    reset = 1'b0;
    tick();
    test_reset_values();
    test_direct_regs();
    test_chipset_staging();
    test_read_back();
    test_buffer_pixels();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
rtl/osd_pkg.sv
rtl/osd_spi_slave.sv
rtl/osd_cmd_regs.sv
rtl/osd_video.sv
rtl/osd_top.sv
verif/osd_tb.sv

//--- Bender.yml
package:
  name: osd_ctrl

sources:
  - files:
      - rtl/osd_pkg.sv
      - rtl/osd_spi_slave.sv
      - rtl/osd_cmd_regs.sv
      - rtl/osd_video.sv
      - rtl/osd_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/osd_tb.sv
